/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - verilog/operandDecode.sv
      - hazard/hazardUnit.sv
      - hazard/forwardUnit.sv
      - verilog/stageRegs.sv
      - verilog/pipeCtrlTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/pipeCtrl_checker.sv
      - sim/pipeCtrl_tb.sv

/* common/isaPkg.sv */
`include "pipe_settings.svh"

package isaPkg;

    // Opcode encodings of the 16-bit load/store ISA
    // Jumps and branches sit in the 001xx and 011xx groups
    typedef enum logic [`OPCODE_W-1:0] {
        opHalt   = 5'b00000,
        opNop    = 5'b00001,
        opJ      = 5'b00100,
        opJr     = 5'b00101,
        opJal    = 5'b00110,
        opJalr   = 5'b00111,
        opAddi   = 5'b01000,
        opSubi   = 5'b01001,
        opXori   = 5'b01010,
        opAndni  = 5'b01011,
        opBeqz   = 5'b01100,
        opBnez   = 5'b01101,
        opBltz   = 5'b01110,
        opBgez   = 5'b01111,
        opSt     = 5'b10000,
        opLd     = 5'b10001,
        opSlbi   = 5'b10010,
        opStu    = 5'b10011,
        opRoli   = 5'b10100,
        opSlli   = 5'b10101,
        opRori   = 5'b10110,
        opSrli   = 5'b10111,
        opLbi    = 5'b11000,
        opBtr    = 5'b11001,
        opShiftR = 5'b11010,
        opAluR   = 5'b11011,
        opSeq    = 5'b11100,
        opSlt    = 5'b11101,
        opSle    = 5'b11110,
        opSco    = 5'b11111
    } opcodeT;

    // Which fields an opcode really touches
    typedef struct packed {
        // srcA read as a register
        logic usesA;
        // srcB read as a register, store data included
        logic usesB;
        // dest written at writeback
        logic writesDest;
        logic isLoad;
        logic isStore;
        // Jump or branch, redirects fetch
        logic isControl;
        logic isHalt;
    } operandUseT;

endpackage

/* common/pipePkg.sv */
`include "pipe_settings.svh"

package pipePkg;

    import isaPkg::*;

    // Decoded fields of one instruction, moves from stage to stage
    typedef struct packed {
        opcodeT opcode;
        logic [`REG_W-1:0] srcA;
        logic [`REG_W-1:0] srcB;
        logic [`REG_W-1:0] dest;
        // For tracing only
        logic [`PC_W-1:0] pc;
    } instrFieldsT;

    // Contents of every stage in one bundle
    typedef struct packed {
        instrFieldsT fetch;
        instrFieldsT decode;
        instrFieldsT execute;
        instrFieldsT memory;
        instrFieldsT writeback;
    } stageBankT;

    // Stall and flush controls toward fetch and the stage latches
    typedef struct packed {
        logic disablePcWrite;
        logic disableIfIdWrite;
        logic setExNop;
        logic setFetchNop;
    } hazardCtrlT;

    // Forwarding mux selects for the execute operands and store data
    typedef struct packed {
        logic exExA;
        logic exExB;
        logic memExA;
        logic memExB;
        logic memMem;
    } fwdSelT;

endpackage

/* common/pipe_settings.svh */
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Opcode field width of the instruction word
`define OPCODE_W 5

// Register number width, 16 architectural registers
`define REG_W 4

// Program counter width, traced through the stages only
`define PC_W 16

// Fetch, decode, execute, memory, writeback
`define PIPE_DEPTH 5

`endif

/* hazard/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  stageBankT  stages,
    input  operandUseT useE,
    input  operandUseT useM,
    output fwdSelT     fwd
);

    operandUseT useW;
    logic       exMemWrites;

    // Writeback writer class
    operandDecode wbDecode (
        .opcode (stages.writeback.opcode),
        .opUse  (useW)
    );

    // Load result is not available until after memory
    assign exMemWrites = useM.writesDest && !useM.isLoad;

    // EX/MEM result into execute operands
    assign fwd.exExA = useE.usesA && exMemWrites
                    && (stages.execute.srcA == stages.memory.dest);
    assign fwd.exExB = useE.usesB && exMemWrites
                    && (stages.execute.srcB == stages.memory.dest);

    // MEM/WB result into execute operands, loads included
    assign fwd.memExA = useE.usesA && useW.writesDest
                     && (stages.execute.srcA == stages.writeback.dest);
    assign fwd.memExB = useE.usesB && useW.writesDest
                     && (stages.execute.srcB == stages.writeback.dest);

    // Store data in memory taken from the MEM/WB result
    // Covers a store directly behind an ALU producer
    assign fwd.memMem = useM.isStore && useW.writesDest
                     && (stages.memory.srcB == stages.writeback.dest);

endmodule

/* hazard/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stageBankT  stages,
    input  operandUseT useF,
    input  operandUseT useD,
    input  operandUseT useE,
    input  operandUseT useM,
    output hazardCtrlT ctrl
);

    logic readsLoadA;
    logic readsLoadB;
    logic loadUse;
    logic ctrlHazard;
    logic fetchIsNop;
    logic fetchNopNext;
    logic setFetchNopQ;

    // Decode operand matches the load destination in execute
    assign readsLoadA = useD.usesA && (stages.decode.srcA == stages.execute.dest);
    assign readsLoadB = useD.usesB && (stages.decode.srcB == stages.execute.dest);

    // Load data is not ready until memory, so decode waits one cycle
    // Masked while reset holds the latches
    assign loadUse = !rst && useE.isLoad && (readsLoadA || readsLoadB);

    // Any jump or branch still ahead of writeback blocks fetch
    assign ctrlHazard = useF.isControl || useD.isControl
                     || useE.isControl || useM.isControl;

    assign fetchIsNop = (stages.fetch.opcode == opNop);

    // Halt at fetch stops the PC so nothing past it is fetched
    assign ctrl.disablePcWrite = loadUse || ctrlHazard || useF.isHalt;

    // Decode instruction held, bubble goes into execute
    assign ctrl.disableIfIdWrite = loadUse;
    assign ctrl.setExNop         = loadUse;

    // Flush fetch behind a control op
    // During a stall only when fetch already holds a bubble
    assign fetchNopNext = (ctrlHazard && !loadUse)
                       || (ctrlHazard && loadUse && fetchIsNop);

    // Takes effect on the IF/ID latch one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            setFetchNopQ <= 1'b0;
        end else begin
            setFetchNopQ <= fetchNopNext;
        end
    end

    assign ctrl.setFetchNop = setFetchNopQ;

endmodule

/* sim/pipeCtrl_checker.sv */
`timescale 1ns/1ps

module pipeCtrl_checker
    import isaPkg::*;
    import pipePkg::*;
(
    input logic       clk,
    input logic       rst,
    input hazardCtrlT hazard,
    input fwdSelT     fwd,
    input stageBankT  stages
);

    // Tally of failed assertions
    int assertFails = 0;

    // Bubble lands in execute on the edge after a stall
    assert property (@(posedge clk) disable iff (rst)
        hazard.setExNop |=> (stages.execute.opcode == opNop))
        else begin
            $error("execute not a bubble after setExNop");
            assertFails++;
        end

    // Decode keeps its instruction through a stall unless flushed
    assert property (@(posedge clk) disable iff (rst)
        (hazard.disableIfIdWrite && !hazard.setFetchNop) |=> $stable(stages.decode))
        else begin
            $error("decode changed during disableIfIdWrite");
            assertFails++;
        end

    // From the second reset cycle on the latches are clear
    assert property (@(posedge clk) (rst ##1 rst) |-> (hazard == '0) && (fwd == '0))
        else begin
            $error("control output active during reset");
            assertFails++;
        end

    // Load result in EX/MEM does not exist yet
    assert property (@(posedge clk) disable iff (rst)
        (stages.memory.opcode == opLd) |-> !fwd.exExA)
        else begin
            $error("exExA raised with a load in EX/MEM");
            assertFails++;
        end

endmodule

bind pipeCtrlTop pipeCtrl_checker hazardFwdChecks (
    .clk    (clk),
    .rst    (rst),
    .hazard (hazard),
    .fwd    (fwd),
    .stages (stages)
);

/* sim/pipeCtrl_tb.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module pipeCtrl_tb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 5;
    localparam int DriveDelay  = 2;

    // One cycle of stimulus with the outputs expected in that cycle
    typedef struct packed {
        logic [7:0]  testId;
        instrFieldsT instr;
        hazardCtrlT  expHaz;
        fwdSelT      expFwd;
    } rowT;

    logic        clk;
    logic        rst;
    instrFieldsT fetchInstr;
    hazardCtrlT  hazard;
    fwdSelT      fwd;

    rowT               stimRows[$];
    int                errorCount;
    int                checkCount;
    int                testCount;
    int                testStartErrors;
    int                cycleCount;
    int                cycleLimit = 0;
    int                pcNext;
    logic [`REG_W-1:0] regP;
    logic [`REG_W-1:0] regQ;
    logic [`REG_W-1:0] regR;

    pipeCtrlTop dut (
        .clk        (clk),
        .rst        (rst),
        .fetchInstr (fetchInstr),
        .hazard     (hazard),
        .fwd        (fwd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    // Ends a stuck run, limit comes from the table length
    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic checkValue(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR time %0t: %s expected %0b got %0b", $time, name, expected, actual);
        end
    endtask

    task automatic compareRow(input rowT row);
        checkValue("disablePcWrite", row.expHaz.disablePcWrite, hazard.disablePcWrite);
        checkValue("disableIfIdWrite", row.expHaz.disableIfIdWrite, hazard.disableIfIdWrite);
        checkValue("setExNop", row.expHaz.setExNop, hazard.setExNop);
        checkValue("setFetchNop", row.expHaz.setFetchNop, hazard.setFetchNop);
        checkValue("exExA", row.expFwd.exExA, fwd.exExA);
        checkValue("exExB", row.expFwd.exExB, fwd.exExB);
        checkValue("memExA", row.expFwd.memExA, fwd.memExA);
        checkValue("memExB", row.expFwd.memExB, fwd.memExB);
        checkValue("memMem", row.expFwd.memMem, fwd.memMem);
    endtask

    // Hazard bits {pcHold, ifIdHold, exNop, fetchNop}, fwd bits in struct order
    task automatic addRow(
        input int                testId,
        input opcodeT            op,
        input logic [`REG_W-1:0] srcA,
        input logic [`REG_W-1:0] srcB,
        input logic [`REG_W-1:0] dest,
        input logic [3:0]        expHaz,
        input logic [4:0]        expFwd
    );
        rowT row;
        // PC moves on unless the previous cycle held it
        if (stimRows.size() > 0 && !stimRows[stimRows.size() - 1].expHaz.disablePcWrite) begin
            pcNext = pcNext + 2;
        end
        row.testId      = testId[7:0];
        row.instr.opcode = op;
        row.instr.srcA  = srcA;
        row.instr.srcB  = srcB;
        row.instr.dest  = dest;
        row.instr.pc    = pcNext[`PC_W-1:0];
        row.expHaz      = expHaz;
        row.expFwd      = expFwd;
        stimRows.push_back(row);
    endtask

    task automatic buildTable();
        regP = `REG_W'($urandom_range(15, 0));
        regQ = `REG_W'($urandom_range(15, 0));
        regR = `REG_W'($urandom_range(15, 0));
        // Reset state, NOP fetched
        addRow(1, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        addRow(1, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        // Producer then dependents, flags follow the register equalities
        addRow(2, opAluR, regQ, regQ, regP, 4'b0000, 5'b00000);
        addRow(2, opAluR, regP, regQ, regR, 4'b0000, 5'b00000);
        addRow(2, opSeq, regQ, regP, regR, 4'b0000, 5'b00000);
        // Unused fields name registers that are being written
        addRow(2, opAddi, regQ, regR, regQ, 4'b0000, {1'b1, regQ == regP, 3'b000});
        addRow(2, opLbi, regQ, regR, regR, 4'b0000,
               {regQ == regR, regP == regR, regQ == regP, 2'b10});
        // Immediate reads A only, LBI reads nothing
        addRow(2, opNop, 0, 0, 0, 4'b0000, {regQ == regR, 1'b0, regQ == regR, 2'b00});
        addRow(2, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        // Load then dependent ALU op, the addi is fetched twice
        addRow(3, opLd, 1, 0, 5, 4'b0000, 5'b00000);
        addRow(3, opAluR, 5, 2, 6, 4'b0000, 5'b00000);
        addRow(3, opAddi, 3, 0, 3, 4'b1110, 5'b00000);
        addRow(3, opAddi, 3, 0, 3, 4'b0000, 5'b00000);
        addRow(3, opNop, 0, 0, 0, 4'b0000, 5'b00100);
        addRow(3, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        // ALU result stored next, exEx on B then memMem
        addRow(4, opAluR, 1, 2, 9, 4'b0000, 5'b00000);
        addRow(4, opSt, 3, 9, 0, 4'b0000, 5'b00000);
        addRow(4, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        addRow(4, opNop, 0, 0, 0, 4'b0000, 5'b01000);
        addRow(4, opNop, 0, 0, 0, 4'b0000, 5'b00001);
        // Store data from a load stalls, bubble splits them so memExB instead
        addRow(4, opLd, 4, 0, 10, 4'b0000, 5'b00000);
        addRow(4, opSt, 3, 10, 0, 4'b0000, 5'b00000);
        addRow(4, opNop, 0, 0, 0, 4'b1110, 5'b00000);
        addRow(4, opNop, 0, 0, 0, 4'b0000, 5'b00000);
        addRow(4, opNop, 0, 0, 0, 4'b0000, 5'b00010);
        // Branch held at fetch until it leaves memory
        addRow(5, opBeqz, 1, 0, 0, 4'b1000, 5'b00000);
        addRow(5, opBeqz, 1, 0, 0, 4'b1001, 5'b00000);
        addRow(5, opBeqz, 1, 0, 0, 4'b1001, 5'b00000);
        addRow(5, opBeqz, 1, 0, 0, 4'b1001, 5'b00000);
        // Redirected, last flush still pending
        addRow(5, opNop, 0, 0, 0, 4'b0001, 5'b00000);
        // Halt stops the PC with no flush
        addRow(6, opHalt, 0, 0, 0, 4'b1000, 5'b00000);
        addRow(6, opHalt, 0, 0, 0, 4'b1000, 5'b00000);
        addRow(6, opHalt, 0, 0, 0, 4'b1000, 5'b00000);
    endtask

    initial begin
        void'($urandom(32'ha10a24b2));
        errorCount      = 0;
        checkCount      = 0;
        testCount       = 0;
        testStartErrors = 0;
        pcNext          = 0;
        rst             = 1'b1;
        fetchInstr      = '0;
        fetchInstr.opcode = opNop;
        buildTable();
        cycleLimit = stimRows.size() + ResetCycles + 20;

        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;

        for (int i = 0; i < stimRows.size(); i++) begin
            @(posedge clk);
            #DriveDelay;
            fetchInstr = stimRows[i].instr;
            // Sample late in the cycle, before the next edge
            #(ClkPeriod - 3 * DriveDelay);
            compareRow(stimRows[i]);
            if (i == stimRows.size() - 1 || stimRows[i + 1].testId != stimRows[i].testId) begin
                testCount++;
                $display("Test %0d finished, %0d mismatches", stimRows[i].testId,
                         errorCount - testStartErrors);
                testStartErrors = errorCount;
            end
        end

        errorCount = errorCount + dut.hazardFwdChecks.assertFails;
        $display("Tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 testCount, checkCount, dut.hazardFwdChecks.assertFails, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
verilog/operandDecode.sv
hazard/hazardUnit.sv
hazard/forwardUnit.sv
verilog/stageRegs.sv
verilog/pipeCtrlTop.sv
sim/pipeCtrl_checker.sv
sim/pipeCtrl_tb.sv

/* verilog/operandDecode.sv */
`timescale 1ns/1ps

module operandDecode
    import isaPkg::*;
(
    input  opcodeT     opcode,
    output operandUseT opUse
);

    always_comb begin
        opUse = '0;
        case (opcode)
            opHalt: begin
                opUse.isHalt = 1'b1;
            end
            // Bubble, touches nothing
            opNop: begin
                opUse = '0;
            end
            // Jumps with immediate target, no register read
            opJ: begin
                opUse.isControl = 1'b1;
            end
            opJal: begin
                opUse.isControl  = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Register-indirect jumps read srcA
            opJr: begin
                opUse.isControl = 1'b1;
                opUse.usesA     = 1'b1;
            end
            opJalr: begin
                opUse.isControl  = 1'b1;
                opUse.usesA      = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Branches test srcA against zero
            opBeqz, opBnez, opBltz, opBgez: begin
                opUse.isControl = 1'b1;
                opUse.usesA     = 1'b1;
            end
            // Immediate ALU, srcB slot holds immediate bits
            opAddi, opSubi, opXori, opAndni,
            opRoli, opSlli, opRori, opSrli: begin
                opUse.usesA      = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Store data comes from srcB
            opSt: begin
                opUse.usesA   = 1'b1;
                opUse.usesB   = 1'b1;
                opUse.isStore = 1'b1;
            end
            // Store with base update
            opStu: begin
                opUse.usesA      = 1'b1;
                opUse.usesB      = 1'b1;
                opUse.isStore    = 1'b1;
                opUse.writesDest = 1'b1;
            end
            opLd: begin
                opUse.usesA      = 1'b1;
                opUse.isLoad     = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Pure immediate load
            opLbi: begin
                opUse.writesDest = 1'b1;
            end
            // SLBI shifts srcA, BTR reverses srcA
            opSlbi, opBtr: begin
                opUse.usesA      = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Register-register ALU and set ops
            opShiftR, opAluR, opSeq, opSlt, opSle, opSco: begin
                opUse.usesA      = 1'b1;
                opUse.usesB      = 1'b1;
                opUse.writesDest = 1'b1;
            end
            // Unassigned encodings act as a bubble
            default: begin
                opUse = '0;
            end
        endcase
    end

endmodule

/* verilog/pipeCtrlTop.sv */
`timescale 1ns/1ps

module pipeCtrlTop
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrFieldsT fetchInstr,
    output hazardCtrlT  hazard,
    output fwdSelT      fwd
);

    stageBankT  stages;
    operandUseT useF;
    operandUseT useD;
    operandUseT useE;
    operandUseT useM;

    // Pipeline latches, controlled by the hazard block
    stageRegs stageRegsInst (
        .clk        (clk),
        .rst        (rst),
        .fetchInstr (fetchInstr),
        .ctrl       (hazard),
        .stages     (stages)
    );

    // Operand usage per stage
    operandDecode fetchDecode (
        .opcode (stages.fetch.opcode),
        .opUse  (useF)
    );

    operandDecode decodeDecode (
        .opcode (stages.decode.opcode),
        .opUse  (useD)
    );

    operandDecode execDecode (
        .opcode (stages.execute.opcode),
        .opUse  (useE)
    );

    operandDecode memDecode (
        .opcode (stages.memory.opcode),
        .opUse  (useM)
    );

    // Stall and flush
    hazardUnit hazardInst (
        .clk    (clk),
        .rst    (rst),
        .stages (stages),
        .useF   (useF),
        .useD   (useD),
        .useE   (useE),
        .useM   (useM),
        .ctrl   (hazard)
    );

    // Bypass selects
    forwardUnit forwardInst (
        .stages (stages),
        .useE   (useE),
        .useM   (useM),
        .fwd    (fwd)
    );

endmodule

/* verilog/stageRegs.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module stageRegs
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrFieldsT fetchInstr,
    input  hazardCtrlT  ctrl,
    output stageBankT   stages
);

    // Bubble pattern loaded on reset and flush
    localparam instrFieldsT NopInstr = '{
        opcode: opNop,
        srcA:   '0,
        srcB:   '0,
        dest:   '0,
        pc:     '0
    };

    // Latch count is one less than the depth
    localparam int NumLatch = `PIPE_DEPTH - 1;

    // Index 0 IF/ID, 1 ID/EX, 2 EX/MEM, 3 MEM/WB
    instrFieldsT latchQ [NumLatch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumLatch; i++) begin
                latchQ[i] <= NopInstr;
            end
        end else begin
            // Flush wins over the stall hold
            if (ctrl.setFetchNop) begin
                latchQ[0] <= NopInstr;
            end else if (!ctrl.disableIfIdWrite) begin
                latchQ[0] <= fetchInstr;
            end

            // Bubble into execute while decode is held
            if (ctrl.setExNop) begin
                latchQ[1] <= NopInstr;
            end else begin
                latchQ[1] <= latchQ[0];
            end

            // Back half never stalls
            for (int i = 2; i < NumLatch; i++) begin
                latchQ[i] <= latchQ[i-1];
            end
        end
    end

    // Fetch position is the live instruction at the PC
    assign stages.fetch     = fetchInstr;
    assign stages.decode    = latchQ[0];
    assign stages.execute   = latchQ[1];
    assign stages.memory    = latchQ[2];
    assign stages.writeback = latchQ[3];

endmodule
